// File: logic/psram_pkg.sv
//==========================================================================
// psram controller shared definitions
// widths, serial command opcodes and the command frame layout used
// between the sequencer and the serial shifter
//==========================================================================

package psram_pkg;

	// byte address and host word sizes
	localparam int addr_w = 24;
	localparam int word_w = 32;
	localparam int word_bytes = 4;

	// serial command bytes
	localparam logic [7:0] op_rsten = 8'h66;
	localparam logic [7:0] op_rst = 8'h99;
	localparam logic [7:0] op_write = 8'h02;
	localparam logic [7:0] op_read = 8'h03;

	// opcode goes out first, then the address, MSB first
	typedef struct packed {
		logic [7:0] opcode;
		logic [addr_w-1:0] addr;
	} cmd_fields_t;

	// same word seen as a plain shift vector by the shifter
	typedef union packed {
		cmd_fields_t fields;
		logic [31:0] bits;
	} cmd_frame_u;

	// frame length in bits, up to 32
	typedef logic [5:0] shift_cnt_t;

endpackage

// File: logic/host_req_if.sv
//==========================================================================
// host request channel
// carries one latched word request from the host port to the sequencer
// and returns completion with the read word
//==========================================================================

`timescale 1ns/1ps

interface host_req_if;

	// request side, held stable while pending
	logic pending;
	logic write;
	logic [psram_pkg::addr_w-1:0] addr;
	logic [psram_pkg::word_w-1:0] wdata;

	// sequencer side
	logic taken;
	logic done;
	logic [psram_pkg::word_w-1:0] rdata;

	modport port(output pending, write, addr, wdata, input taken, done, rdata);
	modport seq(input pending, write, addr, wdata, output taken, done, rdata);

endinterface

// File: logic/spi_frame_if.sv
//==========================================================================
// serial frame channel
// one shift frame from the sequencer to the serial shifter, with the
// shifted-in word and a done pulse coming back
//==========================================================================

`timescale 1ns/1ps

interface spi_frame_if;

	// frame request, start is a single-cycle pulse
	logic start;
	psram_pkg::cmd_frame_u frame;
	psram_pkg::shift_cnt_t nbits;
	logic keep_ce;

	// shifter status
	logic busy;
	logic done;
	logic [31:0] rx;

	modport seq(output start, frame, nbits, keep_ce, input busy, done, rx);
	modport shift(input start, frame, nbits, keep_ce, output busy, done, rx);

endinterface

// File: logic/host_req_port.sv
//==========================================================================
// host request port
// four-phase req/ack handshake with the host; latches one request and
// holds it for the sequencer, then returns the read word with ack
//==========================================================================

`timescale 1ns/1ps

module host_req_port (
	input logic clk,
	input logic rst,
	input logic req,
	input logic write,
	input logic [psram_pkg::addr_w-1:0] addr,
	input logic [psram_pkg::word_w-1:0] wdata,
	output logic ack,
	output logic [psram_pkg::word_w-1:0] rdata,
	host_req_if.port q
);

	typedef enum logic [1:0] {WAIT_REQ, BUSY, ACK_HIGH} state_t;

	state_t state;
	// set once the sequencer has picked this request up
	logic started;

	assign q.pending = (state == BUSY);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WAIT_REQ;
			ack <= 1'b0;
			started <= 1'b0;
		end else begin
			case (state)
				WAIT_REQ: if (req) begin
					state <= BUSY;
					started <= 1'b0;
				end
				BUSY: begin
					if (q.taken)
						started <= 1'b1;
					if (q.done && started) begin
						ack <= 1'b1;
						state <= ACK_HIGH;
					end
				end
				// hold ack while the host keeps req up
				ACK_HIGH: if (!req) begin
					ack <= 1'b0;
					state <= WAIT_REQ;
				end
				default: state <= WAIT_REQ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT_REQ && req) begin
			q.write <= write;
			q.addr <= addr;
			q.wdata <= wdata;
		end
		if (state == BUSY && q.done)
			rdata <= q.rdata;
	end

endmodule

// File: logic/psram_sequencer.sv
//==========================================================================
// psram command sequencer
// waits out power-up, issues reset-enable and reset, then turns each
// host request into a command frame followed by a 32-bit data frame
//==========================================================================

`timescale 1ns/1ps

module psram_sequencer #(
	parameter int boot_ticks = 2000
) (
	input logic clk,
	input logic rst,
	host_req_if.seq q,
	spi_frame_if.seq f,
	output logic ready
);

	localparam int cnt_w = $clog2(boot_ticks + 1);

	typedef enum logic [2:0] {BOOT, RSTEN, GAP, RST, IDLE, CMD, DATA} state_t;

	state_t state;
	logic [cnt_w-1:0] boot_cnt;

	always_ff @(posedge clk) begin
		f.start <= 1'b0;
		q.taken <= 1'b0;
		q.done <= 1'b0;
		if (rst) begin
			state <= BOOT;
			boot_cnt <= '0;
			ready <= 1'b0;
			f.keep_ce <= 1'b0;
		end else begin
			case (state)
				// power-up wait, shifter keeps CE high and SCLK low
				BOOT: begin
					if (boot_cnt == cnt_w'(boot_ticks - 1))
						state <= RSTEN;
					else
						boot_cnt <= boot_cnt + 1'b1;
				end
				RSTEN: if (!f.busy) begin
					f.start <= 1'b1;
					f.frame.fields.opcode <= psram_pkg::op_rsten;
					f.frame.fields.addr <= '0;
					f.nbits <= psram_pkg::shift_cnt_t'(8);
					f.keep_ce <= 1'b0;
					state <= GAP;
				end
				// shifter holds CE high for a period after the frame
				GAP: if (f.done)
					state <= RST;
				RST: if (!f.busy) begin
					f.start <= 1'b1;
					f.frame.fields.opcode <= psram_pkg::op_rst;
					f.frame.fields.addr <= '0;
					f.nbits <= psram_pkg::shift_cnt_t'(8);
					f.keep_ce <= 1'b0;
					state <= IDLE;
				end
				IDLE: begin
					// start-up is over once the reset frame has drained
					if (!f.busy && !f.start)
						ready <= 1'b1;
					if (ready && q.pending && !f.busy) begin
						f.start <= 1'b1;
						q.taken <= 1'b1;
						f.frame.fields.opcode <= q.write ? psram_pkg::op_write
							: psram_pkg::op_read;
						f.frame.fields.addr <= q.addr;
						f.nbits <= psram_pkg::shift_cnt_t'(8 + psram_pkg::addr_w);
						f.keep_ce <= 1'b1;
						state <= CMD;
					end
				end
				// CE stays low into the data phase
				CMD: if (f.done) begin
					f.start <= 1'b1;
					f.frame.bits <= q.write ? q.wdata : '0;
					f.nbits <= psram_pkg::shift_cnt_t'(psram_pkg::word_bytes * 8);
					f.keep_ce <= 1'b0;
					state <= DATA;
				end
				DATA: if (f.done) begin
					q.rdata <= f.rx;
					q.done <= 1'b1;
					state <= IDLE;
				end
				default: state <= BOOT;
			endcase
		end
	end

endmodule

// File: logic/spi_shifter.sv
//==========================================================================
// serial shifter, SPI mode 0
// divides the clock into SCLK half periods, drives CE, shifts a frame
// out MSB first on falling edges and samples MISO on rising edges
//==========================================================================

`timescale 1ns/1ps

module spi_shifter #(
	parameter int clk_div = 2
) (
	input logic clk,
	input logic rst,
	spi_frame_if.shift f,
	output logic ce,
	output logic sclk,
	output logic mosi,
	input logic miso
);

	localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

	logic [div_w-1:0] div_cnt;
	psram_pkg::shift_cnt_t bit_cnt;
	logic [31:0] tx_sr;
	logic keep;
	// CE-high recovery after a frame that closes the command
	logic gap;

	always_ff @(posedge clk) begin
		f.done <= 1'b0;
		if (rst) begin
			f.busy <= 1'b0;
			ce <= 1'b1;
			sclk <= 1'b0;
			mosi <= 1'b0;
			gap <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!f.busy) begin
			div_cnt <= '0;
			if (f.start) begin
				// first bit is on mosi before the first rising edge
				f.busy <= 1'b1;
				ce <= 1'b0;
				mosi <= f.frame.bits[31];
				tx_sr <= {f.frame.bits[30:0], 1'b0};
				bit_cnt <= f.nbits;
				keep <= f.keep_ce;
			end
		end else if (div_cnt != div_w'(clk_div - 1)) begin
			div_cnt <= div_cnt + 1'b1;
		end else begin
			div_cnt <= '0;
			if (gap) begin
				// two half periods with CE high
				if (bit_cnt == 1) begin
					gap <= 1'b0;
					f.busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt - 1'b1;
				end
			end else if (!sclk) begin
				sclk <= 1'b1;
				f.rx <= {f.rx[30:0], miso};
			end else begin
				sclk <= 1'b0;
				if (bit_cnt == 1) begin
					f.done <= 1'b1;
					if (keep) begin
						f.busy <= 1'b0;
					end else begin
						ce <= 1'b1;
						gap <= 1'b1;
						bit_cnt <= psram_pkg::shift_cnt_t'(2);
					end
				end else begin
					bit_cnt <= bit_cnt - 1'b1;
					mosi <= tx_sr[31];
					tx_sr <= {tx_sr[30:0], 1'b0};
				end
			end
		end
	end

endmodule

// File: logic/psram_ctrl_top.sv
//==========================================================================
// serial psram controller top level
// host handshake port, command sequencer and SPI shifter
//==========================================================================

`timescale 1ns/1ps

module psram_ctrl_top #(
	parameter int boot_ticks = 2000,
	parameter int clk_div = 2
) (
	input logic clk,
	input logic rst,
	input logic req,
	input logic write,
	input logic [psram_pkg::addr_w-1:0] addr,
	input logic [psram_pkg::word_w-1:0] wdata,
	output logic ack,
	output logic [psram_pkg::word_w-1:0] rdata,
	output logic ready,
	output logic ce,
	output logic sclk,
	output logic mosi,
	input logic miso
);

	host_req_if req_ch ();
	spi_frame_if frame_ch ();

	host_req_port host_req_port_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.write(write),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.q(req_ch.port)
	);

	psram_sequencer #(
		.boot_ticks(boot_ticks)
	) psram_sequencer_i (
		.clk(clk),
		.rst(rst),
		.q(req_ch.seq),
		.f(frame_ch.seq),
		.ready(ready)
	);

	spi_shifter #(
		.clk_div(clk_div)
	) spi_shifter_i (
		.clk(clk),
		.rst(rst),
		.f(frame_ch.shift),
		.ce(ce),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso)
	);

endmodule

// File: bench/tb_clock.sv
//==========================================================================
// testbench clock and reset
// free-running clock and a synchronous reset held for a few cycles
//==========================================================================

`timescale 1ns/1ps

module tb_clock #(
	parameter int period_ns = 10,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
	end

	always #(period_ns / 2) clk = ~clk;

endmodule

// File: bench/psram_model.sv
//==========================================================================
// behavioural serial PSRAM, SPI mode 0
// decodes 66h/99h/02h/03h frames from the serial pins, keeps a sparse
// byte memory and reports each CE-low window to the checker
//==========================================================================

`timescale 1ns/1ps

module psram_model (
	input logic ce,
	input logic sclk,
	input logic mosi,
	output logic miso,
	output int nframes,
	output logic [7:0] frame_op,
	output logic [23:0] frame_addr,
	output int frame_nbits,
	output logic [31:0] frame_data,
	output logic [63:0] gap_ns
);

	logic [7:0] mem [int];
	logic [63:0] sr;
	logic [7:0] op;
	logic [31:0] rd_word;
	logic [63:0] t_rise;
	int nbits;
	bit in_frame;

	// untouched bytes follow the power-up pattern
	function automatic logic [7:0] read_byte(input int a);
		if (mem.exists(a))
			return mem[a];
		return 8'(a) ^ 8'h5a;
	endfunction

	initial begin
		miso = 1'b0;
		nframes = 0;
		frame_op = '0;
		frame_addr = '0;
		frame_nbits = 0;
		frame_data = '0;
		gap_ns = '0;
		t_rise = '0;
		sr = '0;
		op = '0;
		rd_word = '0;
		nbits = 0;
		in_frame = 1'b0;
	end

	always @(negedge ce) begin
		if (ce === 1'b0) begin
			in_frame = 1'b1;
			nbits = 0;
			sr = '0;
			op = '0;
			gap_ns = $time - t_rise;
		end
	end

	always @(posedge sclk) begin
		if (in_frame && sclk === 1'b1) begin
			sr = {sr[62:0], mosi};
			nbits++;
			if (nbits == 8)
				op = sr[7:0];
			// address complete, fetch the word for a slow read
			if (nbits == 32 && op == 8'h03)
				rd_word = {read_byte(int'(sr[23:0])), read_byte(int'(sr[23:0]) + 1),
					read_byte(int'(sr[23:0]) + 2), read_byte(int'(sr[23:0]) + 3)};
		end
	end

	// read data changes after the falling edge, MSB first
	always @(negedge sclk) begin
		if (in_frame && op == 8'h03 && nbits >= 32 && nbits < 64)
			miso <= rd_word[63 - nbits];
	end

	always @(posedge ce) begin
		if (in_frame) begin
			in_frame = 1'b0;
			t_rise = $time;
			miso <= 1'b0;
			frame_nbits = nbits;
			frame_op = op;
			frame_addr = '0;
			frame_data = '0;
			// 66h and 99h carry no payload
			if (nbits == 64) begin
				frame_addr = sr[55:32];
				frame_data = (op == 8'h03) ? rd_word : sr[31:0];
				if (op == 8'h02) begin
					for (int i = 0; i < 4; i++)
						mem[int'(sr[55:32]) + i] = sr[31 - 8 * i -: 8];
				end
			end
			nframes++;
		end
	end

endmodule

// File: bench/tb_check.sv
//==========================================================================
// testbench checker
// watches the host handshake and the model's frame reports, keeps a
// shadow of written bytes and compares every transfer with it
//==========================================================================

`timescale 1ns/1ps

module tb_check #(
	parameter int clk_div = 2,
	parameter int period_ns = 10
) (
	input logic clk,
	input logic rst,
	input logic req,
	input logic write,
	input logic [23:0] addr,
	input logic [31:0] wdata,
	input logic ack,
	input logic [31:0] rdata,
	input logic ready,
	input logic ce,
	input int nframes,
	input logic [7:0] frame_op,
	input logic [23:0] frame_addr,
	input int frame_nbits,
	input logic [31:0] frame_data,
	input logic [63:0] gap_ns,
	output int errors,
	output int checks
);

	logic [7:0] shadow [int];
	logic req_q;
	logic ack_q;
	logic ce_q;
	logic ready_q;
	int frames_q;
	int windows;
	bit active;
	logic cur_write;
	logic [23:0] cur_addr;
	logic [31:0] cur_wdata;

	// expected word, first byte in the top position
	function automatic logic [31:0] ref_word(input logic [23:0] a);
		logic [31:0] w;
		int ba;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			ba = int'(a) + i;
			if (shadow.exists(ba))
				w = {w[23:0], shadow[ba]};
			else
				w = {w[23:0], 8'(ba) ^ 8'h5a};
		end
		return w;
	endfunction

	task automatic check_eq(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = %0h, expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic note_fail(input string msg);
		checks++;
		errors++;
		$display("error: %s at %0t", msg, $time);
	endtask

	task automatic check_boot_frame();
		if (nframes == 1) begin
			check_eq("frame_op", frame_op, 8'h66);
			check_eq("frame_nbits", frame_nbits, 8);
		end else if (nframes == 2) begin
			check_eq("frame_op", frame_op, 8'h99);
			check_eq("frame_nbits", frame_nbits, 8);
			if (gap_ns < 2 * clk_div * period_ns)
				note_fail("CE-high gap before the reset command is too short");
		end
	endtask

	task automatic check_transfer();
		check_eq("ce windows", windows, 1);
		check_eq("frame_nbits", frame_nbits, 64);
		check_eq("frame_op", frame_op, cur_write ? 8'h02 : 8'h03);
		check_eq("frame_addr", frame_addr, cur_addr);
		if (cur_write) begin
			check_eq("frame_data", frame_data, cur_wdata);
			for (int i = 0; i < 4; i++)
				shadow[int'(cur_addr) + i] = cur_wdata[31 - 8 * i -: 8];
		end else begin
			check_eq("rdata", rdata, ref_word(cur_addr));
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
	end

	always @(posedge clk) begin
		if (rst) begin
			req_q = 1'b0;
			ack_q = 1'b0;
			ce_q = 1'b1;
			ready_q = 1'b0;
			frames_q = nframes;
			windows = 0;
			active = 1'b0;
		end else begin
			if (nframes != frames_q && !ready)
				check_boot_frame();
			if (ready && !ready_q)
				check_eq("nframes", nframes, 2);
			if (ready && ce_q && !ce)
				windows++;
			if (req && !req_q) begin
				// nothing may reach the pins between ack and the next request
				if (active && windows > 1)
					note_fail("a second CE window appeared after ack");
				cur_write = write;
				cur_addr = addr;
				cur_wdata = wdata;
				windows = 0;
				active = 1'b1;
			end
			if (ack && !ack_q)
				check_transfer();
			if (ack_q && !ack && req_q)
				note_fail("ack fell while req was still high");
			if (ack_q && ack && !req_q)
				note_fail("ack still high one clock after req fell");
			req_q = req;
			ack_q = ack;
			ce_q = ce;
			ready_q = ready;
			frames_q = nframes;
		end
	end

endmodule

// File: bench/tb_psram.sv
//==========================================================================
// psram controller testbench
// xorshift host stimulus through the req/ack port, a behavioural PSRAM
// on the serial pins and a checker that compares every transfer
//==========================================================================

`timescale 1ns/1ps

module tb_psram;

	localparam int boot_ticks = 10;
	localparam int clk_div = 2;
	// one 64-bit transfer takes about 270 clocks
	localparam int max_wait = 1000;

	logic clk;
	logic rst;
	logic req;
	logic write;
	logic [23:0] addr;
	logic [31:0] wdata;
	logic ack;
	logic [31:0] rdata;
	logic ready;
	logic ce;
	logic sclk;
	logic mosi;
	logic miso;

	int nframes;
	logic [7:0] frame_op;
	logic [23:0] frame_addr;
	int frame_nbits;
	logic [31:0] frame_data;
	logic [63:0] gap_ns;
	int errors;
	int checks;

	logic [31:0] rng;
	bit timed_out;
	int tests_run;
	int tests_failed;
	int err_mark;

	tb_clock clock_i (
		.clk(clk),
		.rst(rst)
	);

	psram_ctrl_top #(
		.boot_ticks(boot_ticks),
		.clk_div(clk_div)
	) psram_ctrl_top_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.write(write),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.ready(ready),
		.ce(ce),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso)
	);

	psram_model model_i (
		.ce(ce),
		.sclk(sclk),
		.mosi(mosi),
		.miso(miso),
		.nframes(nframes),
		.frame_op(frame_op),
		.frame_addr(frame_addr),
		.frame_nbits(frame_nbits),
		.frame_data(frame_data),
		.gap_ns(gap_ns)
	);

	tb_check #(
		.clk_div(clk_div)
	) check_i (
		.clk(clk),
		.rst(rst),
		.req(req),
		.write(write),
		.addr(addr),
		.wdata(wdata),
		.ack(ack),
		.rdata(rdata),
		.ready(ready),
		.ce(ce),
		.nframes(nframes),
		.frame_op(frame_op),
		.frame_addr(frame_addr),
		.frame_nbits(frame_nbits),
		.frame_data(frame_data),
		.gap_ns(gap_ns),
		.errors(errors),
		.checks(checks)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (ack !== level && n < max_wait) begin
			@(posedge clk);
			n++;
		end
		if (ack !== level) begin
			$display("timeout: %s", what);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (ready !== 1'b1 && n < max_wait) begin
			@(posedge clk);
			n++;
		end
		if (ready !== 1'b1) begin
			$display("timeout: ready never rose after reset");
			timed_out = 1'b1;
		end
	endtask

	// one four-phase handshake with req kept up for hold extra cycles after ack
	task automatic transfer(input logic wr, input logic [23:0] a, input logic [31:0] d,
		input int hold);
		if (!timed_out) begin
			@(posedge clk);
			req <= 1'b1;
			write <= wr;
			addr <= a;
			wdata <= d;
			wait_ack(1'b1, "ack did not rise for the request");
		end
		if (!timed_out) begin
			repeat (hold) @(posedge clk);
			req <= 1'b0;
			wait_ack(1'b0, "ack did not fall after req fell");
		end
	endtask

	task automatic finish_test(input string name);
		// checker results for the last sampled edge are settled one edge later
		@(posedge clk);
		tests_run++;
		if (timed_out || errors != err_mark) begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - err_mark);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		err_mark = errors;
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [23:0] a;
		req = 1'b0;
		write = 1'b0;
		addr = '0;
		wdata = '0;
		rng = 32'hd0bac6ed;
		timed_out = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		err_mark = 0;

		wait_ready();
		finish_test("start-up");

		next_rand(r);
		transfer(1'b0, r[23:0] & 24'hfffffc, '0, 0);
		finish_test("read untouched");

		next_rand(r);
		next_rand(d);
		a = r[23:0] & 24'hfffffc;
		transfer(1'b1, a, d, 0);
		transfer(1'b0, a, '0, 0);
		finish_test("write then read");

		// small window so reads often hit written words
		for (int i = 0; i < 40; i++) begin
			next_rand(r);
			next_rand(d);
			a = 24'h001000 | {16'h0000, r[7:2], 2'b00};
			transfer(r[8], a, d, 0);
		end
		finish_test("random mix");

		next_rand(r);
		next_rand(d);
		a = 24'h002000 | {16'h0000, r[9:4], 2'b00};
		transfer(1'b1, a, d, 2 + int'(r[2:0]));
		transfer(1'b0, a, '0, 3 + int'(r[12:10]));
		finish_test("held request");

		transfer(1'b1, 24'hfffffc, 32'h8000_0001, 0);
		transfer(1'b0, 24'hfffffc, '0, 0);
		transfer(1'b1, 24'h000000, 32'hffff_ffff, 0);
		transfer(1'b0, 24'h000000, '0, 0);
		finish_test("frame format");

		repeat (4) @(posedge clk);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (timed_out || errors != 0 || tests_failed != 0)
			$display("Regression failed");
		else
			$display("Regression passed");
		$finish;
	end

endmodule

// File: sim.f
logic/psram_pkg.sv
logic/host_req_if.sv
logic/spi_frame_if.sv
logic/host_req_port.sv
logic/psram_sequencer.sv
logic/spi_shifter.sv
logic/psram_ctrl_top.sv
bench/tb_clock.sv
bench/psram_model.sv
bench/tb_check.sv
bench/tb_psram.sv
